//--- verilog/bus_pkg.sv
package bus_pkg;

    // Bus geometry
    localparam int N_MASTERS = 3;
    localparam int ADDR_W    = 6;
    localparam int DATA_W    = 16;

    localparam int MEM_DEPTH   = 2 ** ADDR_W;  // One word per address
    localparam int MEM_LATENCY = 2;            // Grant visible to ack, in cycles

    // One bit per master, used for both requests and grants
    typedef logic [N_MASTERS-1:0] arb_vector;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    localparam arb_vector NO_GRANT = '0;  // Also reads as "no request"

endpackage

//--- verilog/bus_if.sv
`timescale 1ns/100ps

// Shared command path from the multiplexer to the memory target
interface bus_if;

    logic           valid;  // A granted command is on the bus
    logic           write;  // 1 = write, 0 = read
    bus_pkg::addr_t addr;
    bus_pkg::data_t wdata;

    logic           ack;    // One-cycle transfer completion
    bus_pkg::data_t rdata;  // Valid in the ack cycle

    modport initiator (
        output valid,
        output write,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport target (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

//--- verilog/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  bus_pkg::arb_vector bus_req,
    input  logic               bus_ack,
    output bus_pkg::arb_vector bus_grant
);

    typedef enum logic {
        READY,
        BUSY
    } arb_state_t;

    arb_state_t         state;
    bus_pkg::arb_vector done_mask;    // Master finishing this cycle
    bus_pkg::arb_vector masked_req;
    bus_pkg::arb_vector pick;         // Lowest-numbered eligible requester

    // Finishing master sits out the re-arbitration on its own ack
    assign done_mask  = (state == BUSY && bus_ack) ? bus_grant : bus_pkg::NO_GRANT;
    assign masked_req = bus_req & ~done_mask;

    always_comb begin : prio_enc
        logic found;
        found = 1'b0;
        pick  = bus_pkg::NO_GRANT;
        for (int i = 0; i < bus_pkg::N_MASTERS; i++) begin
            if (!found && masked_req[i]) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= READY;
            bus_grant <= bus_pkg::NO_GRANT;
        end else begin
            case (state)
                READY: begin
                    if (pick != bus_pkg::NO_GRANT) begin
                        state     <= BUSY;
                        bus_grant <= pick;
                    end
                end
                BUSY: begin
                    if (bus_ack) begin          // Transfer done, hand over
                        bus_grant <= pick;
                        if (pick == bus_pkg::NO_GRANT) begin
                            state <= READY;
                        end
                    end
                end
                default: begin
                    state     <= READY;
                    bus_grant <= bus_pkg::NO_GRANT;
                end
            endcase
        end
    end

    // At most one owner at any time
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(bus_grant));

    // Owner keeps the bus until the memory acknowledges
    a_grant_hold: assert property (
        @(posedge clk) disable iff (reset)
        (bus_grant != bus_pkg::NO_GRANT && !bus_ack) |=> $stable(bus_grant));

    for (genvar g = 0; g < bus_pkg::N_MASTERS; g++) begin : g_rise_chk
        // No grant without a request one cycle earlier
        a_grant_had_req: assert property (
            @(posedge clk) disable iff (reset)
            $rose(bus_grant[g]) |-> $past(bus_req[g]));
    end

endmodule

//--- verilog/bus_mux.sv
`timescale 1ns/100ps

module bus_mux (
    input  bus_pkg::arb_vector                         bus_grant,
    input  logic           [bus_pkg::N_MASTERS-1:0]    m_write,
    input  bus_pkg::addr_t [bus_pkg::N_MASTERS-1:0]    m_addr,
    input  bus_pkg::data_t [bus_pkg::N_MASTERS-1:0]    m_wdata,
    bus_if.initiator                                   bus
);

    // Grant is one-hot, so at most one master's fields pass
    always_comb begin
        bus.valid = (bus_grant != bus_pkg::NO_GRANT);
        bus.write = 1'b0;
        bus.addr  = '0;
        bus.wdata = '0;
        for (int i = 0; i < bus_pkg::N_MASTERS; i++) begin
            if (bus_grant[i]) begin
                bus.write = m_write[i];
                bus.addr  = m_addr[i];
                bus.wdata = m_wdata[i];
            end
        end
    end

endmodule

//--- verilog/bus_memory.sv
`timescale 1ns/100ps

module bus_memory (
    input  logic  clk,
    input  logic  reset,
    bus_if.target bus
);

    localparam int CNT_W = $clog2(bus_pkg::MEM_LATENCY + 1);

    bus_pkg::data_t mem [bus_pkg::MEM_DEPTH];

    logic [CNT_W-1:0] cnt;       // Cycles of valid seen in this transfer
    logic             ack_q;
    bus_pkg::data_t   rdata_q;

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    // Latency counter, restarts on idle and after every ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt   <= '0;
            ack_q <= 1'b0;
        end else if (!bus.valid || ack_q) begin
            cnt   <= '0;
            ack_q <= 1'b0;
        end else if (cnt == CNT_W'(bus_pkg::MEM_LATENCY - 1)) begin
            cnt   <= '0;
            ack_q <= 1'b1;                  // Ack lands MEM_LATENCY after valid
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Read data sampled before the ack cycle, so a same-cycle write is not seen
    always_ff @(posedge clk) begin
        if (bus.valid && !ack_q && cnt == CNT_W'(bus_pkg::MEM_LATENCY - 1)) begin
            rdata_q <= mem[bus.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (ack_q && bus.write) begin
            mem[bus.addr] <= bus.wdata;     // Write commits at the end of ack
        end
    end

    // Arbiter must still be granting when the memory answers
    a_ack_needs_valid: assert property (
        @(posedge clk) disable iff (reset) bus.ack |-> bus.valid);

    a_ack_one_cycle: assert property (
        @(posedge clk) disable iff (reset) bus.ack |=> !bus.ack);

endmodule

//--- verilog/shared_bus_top.sv
`timescale 1ns/100ps

module shared_bus_top (
    input  logic                                       clk,
    input  logic                                       reset,
    input  bus_pkg::arb_vector                         bus_req,
    input  logic           [bus_pkg::N_MASTERS-1:0]    m_write,
    input  bus_pkg::addr_t [bus_pkg::N_MASTERS-1:0]    m_addr,
    input  bus_pkg::data_t [bus_pkg::N_MASTERS-1:0]    m_wdata,
    output bus_pkg::arb_vector                         bus_grant,
    output logic                                       bus_ack,
    output bus_pkg::data_t                             rdata
);

    bus_if bus ();

    bus_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .bus_ack   (bus.ack),
        .bus_grant (bus_grant)
    );

    bus_mux u_mux (
        .bus_grant (bus_grant),
        .m_write   (m_write),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .bus       (bus.initiator)
    );

    bus_memory u_memory (
        .clk   (clk),
        .reset (reset),
        .bus   (bus.target)
    );

    assign bus_ack = bus.ack;
    assign rdata   = bus.rdata;     // Meaningful only while bus_ack is high

endmodule

//--- dv/shared_bus_tb.sv
`timescale 1ns/100ps

module shared_bus_tb;

    localparam int REC_W   = 18;    // Words per scenario line
    localparam int MAX_REC = 64;

    logic                                         clk;
    logic                                         reset;
    bus_pkg::arb_vector                           bus_req;
    logic           [bus_pkg::N_MASTERS-1:0]      m_write;
    bus_pkg::addr_t [bus_pkg::N_MASTERS-1:0]      m_addr;
    bus_pkg::data_t [bus_pkg::N_MASTERS-1:0]      m_wdata;
    bus_pkg::arb_vector                           bus_grant;
    logic                                         bus_ack;
    bus_pkg::data_t                               rdata;

    logic [15:0] gold [REC_W*MAX_REC];
    int          n_scen;
    logic        loaded;

    bus_pkg::arb_vector prev_grant;     // Monitor history, one cycle back
    logic               prev_ack;
    int                 grant_age;      // Cycles since the current grant appeared
    logic               exp_ack;

    shared_bus_top uut (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .m_write   (m_write),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .bus_grant (bus_grant),
        .bus_ack   (bus_ack),
        .rdata     (rdata)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Per-cycle protocol checks on registered outputs
    always @(posedge clk) begin
        if (reset) begin
            prev_grant = bus_pkg::NO_GRANT;
            prev_ack   = 1'b0;
            grant_age  = 0;
        end else begin
            check_value("bus_grant one-hot",
                        (bus_grant & (bus_grant - bus_pkg::arb_vector'(1))) == '0, 1'b1);
            if (prev_grant != bus_pkg::NO_GRANT && !prev_ack) begin
                check_value("bus_grant hold", bus_grant, prev_grant);
            end
            if (bus_grant != bus_pkg::NO_GRANT && (bus_grant != prev_grant || prev_ack)) begin
                grant_age = 0;                      // Fresh grant this cycle
            end else if (bus_grant != bus_pkg::NO_GRANT) begin
                grant_age = grant_age + 1;
            end
            exp_ack = (bus_grant != bus_pkg::NO_GRANT) && (grant_age == bus_pkg::MEM_LATENCY);
            check_value("bus_ack", bus_ack, exp_ack);
            prev_grant = bus_grant;
            prev_ack   = bus_ack;
        end
    end

    initial begin : watchdog
        int limit;
        wait (loaded === 1'b1);
        limit = n_scen * bus_pkg::N_MASTERS * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_seq
        logic [bus_pkg::N_MASTERS-1:0] active;
        logic [bus_pkg::N_MASTERS-1:0] wr;
        bus_pkg::data_t                exp_rd [bus_pkg::N_MASTERS];
        int                            exp_order [bus_pkg::N_MASTERS];
        int                            n_exp;
        int                            base;
        bus_pkg::arb_vector            pending;
        bus_pkg::arb_vector            seen_grant;
        bus_pkg::arb_vector            rise;
        int                            order_q [$];

        clk     = 1'b0;
        reset   = 1'b1;
        bus_req = bus_pkg::NO_GRANT;
        m_write = '0;
        m_addr  = '0;
        m_wdata = '0;
        loaded  = 1'b0;
        n_scen  = 0;

        for (int w = 0; w < REC_W*MAX_REC; w++) begin
            gold[w] = 16'hffff;             // Marks records past the end of the file
        end
        $readmemh("dv/shared_bus_golden.txt", gold);
        while (n_scen < MAX_REC && gold[n_scen*REC_W] != 16'hffff) begin
            n_scen++;
        end
        loaded = 1'b1;
        if (n_scen == 0) begin
            $display("The golden file holds no scenarios");
            $display("SIMULATION FAILED");
            $fatal(1, "empty golden file");
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Bus must stay idle until somebody asks for it
        repeat (3) begin
            @(posedge clk);
            check_value("bus_grant after reset", bus_grant, bus_pkg::NO_GRANT);
            check_value("bus_ack after reset", bus_ack, 1'b0);
        end

        for (int s = 0; s < n_scen; s++) begin
            base  = s * REC_W;
            n_exp = 0;
            for (int i = 0; i < bus_pkg::N_MASTERS; i++) begin
                active[i]    = gold[base + 4*i] != 0;
                wr[i]        = gold[base + 4*i + 1] != 0;
                exp_order[i] = gold[base + 12 + i];
                exp_rd[i]    = gold[base + 15 + i];
                if (active[i]) begin
                    n_exp++;
                end
            end

            @(posedge clk);
            for (int i = 0; i < bus_pkg::N_MASTERS; i++) begin
                m_write[i] <= wr[i];
                m_addr[i]  <= bus_pkg::addr_t'(gold[base + 4*i + 2]);
                m_wdata[i] <= gold[base + 4*i + 3];
            end
            bus_req <= active;              // All requests rise together

            pending    = active;
            seen_grant = bus_pkg::NO_GRANT;
            order_q.delete();
            while (pending != bus_pkg::NO_GRANT) begin
                @(posedge clk);
                rise = bus_grant & ~seen_grant;
                for (int i = 0; i < bus_pkg::N_MASTERS; i++) begin
                    if (rise[i]) begin
                        order_q.push_back(i);
                    end
                end
                // The finisher's request is still high at this edge, so the
                // arbiter has to skip it for the next owner
                if (bus_ack) begin
                    for (int i = 0; i < bus_pkg::N_MASTERS; i++) begin
                        if (bus_grant[i]) begin
                            if (!wr[i]) begin
                                check_value($sformatf("rdata master %0d", i), rdata, exp_rd[i]);
                            end
                            pending[i] = 1'b0;
                            bus_req[i] <= 1'b0;
                        end
                    end
                end
                // Any grant after an ack is a new one, even for the same master
                seen_grant = bus_ack ? bus_pkg::NO_GRANT : bus_grant;
            end

            @(posedge clk);
            check_value("bus_grant idle", bus_grant, bus_pkg::NO_GRANT);
            check_value("grant count", order_q.size(), n_exp);
            for (int k = 0; k < n_exp; k++) begin
                check_value($sformatf("grant order slot %0d", k), order_q[k], exp_order[k]);
            end
            $display("Scenario %0d done", s);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- dv/shared_bus_golden.txt
// Per line, masters 0..2 as {active write addr wdata}, then grant order (f = none),
// then expected read data for masters 0..2 (0000 where that master does not read)

// Fill three words, one per master
1 1 01 1111  1 1 02 2222  1 1 03 3333  0 1 2  0000 0000 0000

// Read them back crosswise
1 0 03 0000  1 0 01 0000  1 0 02 0000  0 1 2  3333 1111 2222

// Lowest priority master alone
0 0 00 0000  0 0 00 0000  1 1 10 abcd  2 f f  0000 0000 0000

// Middle master alone reads it
0 0 00 0000  1 0 10 0000  0 0 00 0000  1 f f  0000 abcd 0000

// Write then read of one address by two masters
1 1 20 5a5a  1 0 20 0000  0 0 00 0000  0 1 f  0000 5a5a 0000

0 0 00 0000  1 1 3f 0f0f  1 0 3f 0000  1 2 f  0000 0000 0f0f

// Read before a later write to the same word sees the old value
1 0 01 0000  0 0 00 0000  1 1 01 beef  0 2 f  1111 0000 0000

1 0 01 0000  1 1 00 ffff  1 0 00 0000  0 1 2  beef 0000 ffff

// Three writes to one word, the last one wins
1 1 2a 1000  1 1 2a 2000  1 1 2a 3000  0 1 2  0000 0000 0000

1 0 2a 0000  1 0 2a 0000  1 0 2a 0000  0 1 2  3000 3000 3000

// Master 0 idle
0 0 00 0000  1 0 02 0000  1 0 03 0000  1 2 f  0000 2222 3333

// Write, read, write on address 02
1 1 02 c0de  1 0 02 0000  1 1 02 d00d  0 1 2  0000 c0de 0000

1 0 02 0000  1 0 20 0000  1 0 3f 0000  0 1 2  d00d 5a5a 0f0f

1 1 15 0001  1 1 2b 8001  0 0 00 0000  0 1 f  0000 0000 0000

1 0 2b 0000  1 0 10 0000  1 0 15 0000  0 1 2  8001 abcd 0001

// Top master alone, all ones word
1 0 00 0000  0 0 00 0000  0 0 00 0000  0 f f  ffff 0000 0000

//--- build.f
verilog/bus_pkg.sv
verilog/bus_if.sv
verilog/bus_arbiter.sv
verilog/bus_mux.sv
verilog/bus_memory.sv
verilog/shared_bus_top.sv
dv/shared_bus_tb.sv

//--- Makefile
# Verilator build of the shared bus testbench

TOP = shared_bus_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f verilog/*.sv dv/shared_bus_tb.sv
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f build.f -o V$(TOP)

# Runs from the project root so the golden file path resolves
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
